/* logic/spi_macros.svh */
// Register map offsets for the SPI master APB port
// Word length, divider width and chip-select lead and lag timing
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// APB address width and register offsets
`define SPI_APB_AW      8
`define SPI_REG_CTRL    8'h00
`define SPI_REG_DIV     8'h04
`define SPI_REG_TX      8'h08
`define SPI_REG_RX      8'h0C
`define SPI_REG_STATUS  8'h10

// Datapath sizes
`define SPI_MAX_BITS    32
`define SPI_DIV_W       16

// Clock cycles around the shift phase with ss_n low
`define SPI_LEAD_CYCLES 4
`define SPI_LAG_CYCLES  4

`endif

/* logic/spi_pkg.sv */
// Shared types of the SPI master
// Data word, half-period divider, word length code and frame states
`include "spi_macros.svh"

package spi_pkg;

    // One transfer word, right aligned
    typedef logic [`SPI_MAX_BITS-1:0] spi_word_t;

    // Half sclk period minus one, in clock cycles
    typedef logic [`SPI_DIV_W-1:0] spi_div_t;

    // Word length minus one
    typedef logic [$clog2(`SPI_MAX_BITS)-1:0] spi_bits_t;

    // Chip-select framing of one transfer
    typedef enum logic [1:0] {
        IDLE,
        LEAD,
        SHIFT,
        LAG
    } frame_state_t;

endpackage

/* logic/spi_cfg_if.sv */
// Configuration and handshake bundle between the register block,
// the frame controller and the shift engine
`timescale 1ns/1ps

interface spi_cfg_if;
    import spi_pkg::*;

    // Static transfer setup
    logic      cpol;
    logic      cpha;
    logic      lsb_first;
    spi_bits_t bits;
    spi_div_t  div;
    spi_word_t tx_word;

    // Transfer control and result
    logic      start;
    logic      busy;
    logic      finish;
    spi_word_t rx_word;

    modport regs (
        output cpol, cpha, lsb_first, bits, div, tx_word, start,
        input  busy, rx_word, finish
    );

    modport frame (
        input  start, cpol,
        output busy, finish
    );

    modport engine (
        input  cpol, cpha, lsb_first, bits, div, tx_word,
        output rx_word
    );

endinterface

/* logic/spi_apb_regs.sv */
// APB register file of the SPI master
// CTRL, DIV and TX setup, RX capture, sticky done flag and irq
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_apb_regs (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`SPI_APB_AW-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  spi_pkg::spi_word_t     pwdata,
    output spi_pkg::spi_word_t     prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq,
    spi_cfg_if.regs                cfg
);
    import spi_pkg::*;

    logic      access;
    logic      wr;
    logic      rd;
    logic      mapped;
    logic      tx_hit;
    logic      rx_hit;
    logic      tx_accept;
    logic      done;
    spi_word_t rx_q;

    // No wait states, every access phase completes at once
    assign pready = 1'b1;

    assign access = psel && penable;
    assign wr     = access && pwrite;
    assign rd     = access && !pwrite;
    assign tx_hit = (paddr == `SPI_REG_TX);
    assign rx_hit = (paddr == `SPI_REG_RX);

    // A TX write during a transfer is dropped and flagged
    assign tx_accept = wr && tx_hit && !cfg.busy;
    assign pslverr   = access && (!mapped || (pwrite && tx_hit && cfg.busy));

    assign irq = done;

    // Address decode and read mux
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            `SPI_REG_CTRL: begin
                prdata[0]    = cfg.cpol;
                prdata[1]    = cfg.cpha;
                prdata[2]    = cfg.lsb_first;
                prdata[12:8] = cfg.bits;
            end
            `SPI_REG_DIV:    prdata[`SPI_DIV_W-1:0] = cfg.div;
            `SPI_REG_TX:     prdata = cfg.tx_word;
            `SPI_REG_RX:     prdata = rx_q;
            `SPI_REG_STATUS: prdata[1:0] = {done, cfg.busy};
            default:         mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg.cpol      <= 1'b0;
            cfg.cpha      <= 1'b0;
            cfg.lsb_first <= 1'b0;
            cfg.bits      <= '0;
            cfg.div       <= '0;
            cfg.tx_word   <= '0;
            cfg.start     <= 1'b0;
            done          <= 1'b0;
            rx_q          <= '0;
        end else begin
            // Start pulses in the cycle after the accepted TX write
            cfg.start <= tx_accept;

            if (wr && paddr == `SPI_REG_CTRL) begin
                cfg.cpol      <= pwdata[0];
                cfg.cpha      <= pwdata[1];
                cfg.lsb_first <= pwdata[2];
                cfg.bits      <= pwdata[12:8];
            end
            if (wr && paddr == `SPI_REG_DIV) begin
                cfg.div <= pwdata[`SPI_DIV_W-1:0];
            end
            if (tx_accept) begin
                cfg.tx_word <= pwdata;
            end

            if (cfg.finish) begin
                rx_q <= cfg.rx_word;
            end

            // Completion wins over a clearing RX read in the same cycle
            if (cfg.finish) begin
                done <= 1'b1;
            end else if (rd && rx_hit) begin
                done <= 1'b0;
            end
        end
    end

endmodule

/* logic/spi_edge_timer.sv */
// Half-period timer for sclk
// Emits a one-cycle tick every div+1 cycles while run is high
`timescale 1ns/1ps

module spi_edge_timer (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              run,
    input  spi_pkg::spi_div_t div,
    output logic              tick
);
    import spi_pkg::*;

    spi_div_t cnt;

    // First tick comes div cycles after run rises
    assign tick = run && (cnt == div);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* logic/spi_shift_engine.sv */
// Shift engine of the SPI master
// Edge counter, sclk level, transmit and receive shift registers
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_shift_engine (
    input  logic      clock,
    input  logic      rst_n,
    spi_cfg_if.engine cfg,
    input  logic      run,
    input  logic      tick,
    input  logic      miso,
    output logic      sclk_level,
    output logic      mosi_bit,
    output logic      last
);
    import spi_pkg::*;

    localparam int EDGE_W = $clog2(2 * `SPI_MAX_BITS);
    localparam spi_bits_t TOP_BIT = spi_bits_t'(`SPI_MAX_BITS - 1);

    logic [EDGE_W-1:0] edge_cnt;
    logic [EDGE_W-1:0] last_edge;
    logic              odd_edge;
    logic              sample_edge;
    logic              shift_edge;
    logic              sample_q;
    logic              run_q;
    spi_bits_t         pad;
    spi_word_t         tx_aligned;
    spi_word_t         tx_sr;
    spi_word_t         rx_sr;

    // edge_cnt holds the number of edges already made, so edge 1 is count 0
    assign last_edge = {cfg.bits, 1'b1};
    assign odd_edge  = ~edge_cnt[0];
    assign last      = run && tick && (edge_cnt == last_edge);

    // cpha 0 samples on leading edges, cpha 1 on trailing edges
    assign sample_edge = cfg.cpha ? ~odd_edge : odd_edge;
    // With cpha 1 the first bit is already on mosi at edge 1
    assign shift_edge  = cfg.cpha ? (odd_edge && edge_cnt != '0) : ~odd_edge;

    // Unused upper bit positions for the current length
    assign pad = TOP_BIT - cfg.bits;

    assign tx_aligned  = cfg.lsb_first ? cfg.tx_word : (cfg.tx_word << pad);
    assign mosi_bit    = cfg.lsb_first ? tx_sr[0] : tx_sr[`SPI_MAX_BITS-1];
    assign cfg.rx_word = cfg.lsb_first ? (rx_sr >> pad) : rx_sr;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt   <= '0;
            sclk_level <= 1'b0;
            sample_q   <= 1'b0;
            run_q      <= 1'b0;
        end else begin
            run_q <= run;
            // Sampling lags the tick by one cycle, in step with the
            // registered sclk pin
            sample_q <= run && tick && sample_edge;
            if (!run) begin
                edge_cnt   <= '0;
                sclk_level <= cfg.cpol;
            end else if (tick) begin
                edge_cnt   <= edge_cnt + 1'b1;
                sclk_level <= ~sclk_level;
            end
        end
    end

    // Transmit word is reloaded whenever no shift phase is running
    always_ff @(posedge clock) begin
        if (!run) begin
            tx_sr <= tx_aligned;
        end else if (tick && shift_edge) begin
            tx_sr <= cfg.lsb_first ? (tx_sr >> 1) : (tx_sr << 1);
        end
    end

    // Receive register clears on the first shift cycle
    always_ff @(posedge clock) begin
        if (run && !run_q) begin
            rx_sr <= '0;
        end else if (sample_q) begin
            if (cfg.lsb_first) begin
                rx_sr <= {miso, rx_sr[`SPI_MAX_BITS-1:1]};
            end else begin
                rx_sr <= {rx_sr[`SPI_MAX_BITS-2:0], miso};
            end
        end
    end

endmodule

/* logic/spi_frame_ctrl.sv */
// Frame controller of the SPI master
// Lead, shift and lag sequencing and the registered ss_n, sclk and mosi pins
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_frame_ctrl (
    input  logic     clock,
    input  logic     rst_n,
    spi_cfg_if.frame cfg,
    input  logic     last,
    input  logic     sclk_level,
    input  logic     mosi_bit,
    output logic     run,
    output logic     ss_n,
    output logic     sclk,
    output logic     mosi
);
    import spi_pkg::*;

    localparam int CNT_MAX = (`SPI_LEAD_CYCLES > `SPI_LAG_CYCLES) ?
                             `SPI_LEAD_CYCLES : `SPI_LAG_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    frame_state_t     state;
    logic [CNT_W-1:0] cnt;
    logic             ss_n_q;

    assign run        = (state == SHIFT);
    assign cfg.busy   = (state != IDLE) || cfg.start;
    assign cfg.finish = (state == LAG) && (cnt == CNT_W'(`SPI_LAG_CYCLES - 1));

    // Chip select already drops in the start cycle
    assign ss_n = ss_n_q && !cfg.start;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            cnt    <= '0;
            ss_n_q <= 1'b1;
            sclk   <= 1'b0;
            mosi   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // The start cycle counts as the first lead cycle
                    if (cfg.start) begin
                        state <= LEAD;
                        cnt   <= CNT_W'(1);
                    end
                end
                LEAD: begin
                    if (cnt == CNT_W'(`SPI_LEAD_CYCLES - 1)) begin
                        state <= SHIFT;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SHIFT: begin
                    if (last) begin
                        state <= LAG;
                        cnt   <= '0;
                    end
                end
                LAG: begin
                    if (cfg.finish) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase

            if (cfg.start) begin
                ss_n_q <= 1'b0;
            end else if (cfg.finish) begin
                ss_n_q <= 1'b1;
            end

            sclk <= (state == SHIFT) ? sclk_level : cfg.cpol;

            // mosi holds its last bit through lag
            if (state == IDLE && !cfg.start) begin
                mosi <= 1'b0;
            end else if (state != LAG) begin
                mosi <= mosi_bit;
            end
        end
    end

endmodule

/* logic/spi_top.sv */
// Top level of the APB SPI master
// Register block, edge timer, shift engine and frame controller
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`SPI_APB_AW-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  spi_pkg::spi_word_t     pwdata,
    output spi_pkg::spi_word_t     prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   sclk,
    output logic                   mosi,
    input  logic                   miso,
    output logic                   ss_n,
    output logic                   irq
);

    logic run;
    logic last;
    logic tick;
    logic sclk_level;
    logic mosi_bit;

    spi_cfg_if cfg ();

    spi_apb_regs i_regs (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq),
        .cfg     (cfg.regs)
    );

    spi_edge_timer i_timer (
        .clock (clock),
        .rst_n (rst_n),
        .run   (run),
        .div   (cfg.div),
        .tick  (tick)
    );

    spi_shift_engine i_engine (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg        (cfg.engine),
        .run        (run),
        .tick       (tick),
        .miso       (miso),
        .sclk_level (sclk_level),
        .mosi_bit   (mosi_bit),
        .last       (last)
    );

    spi_frame_ctrl i_frame (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg        (cfg.frame),
        .last       (last),
        .sclk_level (sclk_level),
        .mosi_bit   (mosi_bit),
        .run        (run),
        .ss_n       (ss_n),
        .sclk       (sclk),
        .mosi       (mosi)
    );

endmodule

/* testbench/spi_slave_model.sv */
// Behavioral SPI slave for the testbench
// Captures the mosi word and returns a preset reply in any cpol/cpha mode
`timescale 1ns/1ps

module spi_slave_model (
    input  logic        sclk,
    input  logic        mosi,
    input  logic        ss_n,
    input  logic        cpol,
    input  logic        cpha,
    input  logic        lsb_first,
    input  logic [5:0]  len,
    input  logic [31:0] reply,
    output logic        miso,
    output logic [31:0] captured
);

    int   tx_idx;
    int   rx_idx;
    logic leading;

    // Reply bit for a position in transfer order, zero past the word
    function automatic logic reply_bit(input int idx);
        if (idx >= len) begin
            return 1'b0;
        end
        return lsb_first ? reply[idx] : reply[len - 1 - idx];
    endfunction

    initial begin
        miso     = 1'b0;
        captured = '0;
        tx_idx   = 0;
        rx_idx   = 0;
    end

    always @(negedge ss_n) begin
        captured = '0;
        rx_idx   = 0;
        tx_idx   = 0;
        // With cpha 0 the first bit must be valid before the first edge
        if (!cpha) begin
            miso   <= reply_bit(0);
            tx_idx = 1;
        end
    end

    always @(sclk) begin
        if (ss_n === 1'b0) begin
            leading = (sclk != cpol);
            if (leading ^ cpha) begin
                if (lsb_first && rx_idx < 32) begin
                    captured[rx_idx] = mosi;
                end else if (!lsb_first) begin
                    captured = {captured[30:0], mosi};
                end
                rx_idx++;
            end else begin
                miso <= reply_bit(tx_idx);
                tx_idx++;
            end
        end
    end

endmodule

/* testbench/spi_tb.sv */
// Testbench for the APB SPI master
// Transfer table in all modes, APB access task, slave model and watchdog
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_tb;

    localparam int CLK_NS = 4;

    typedef struct {
        string       name;
        logic        cpol;
        logic        cpha;
        logic        lsb;
        int          len;
        int          div;
        logic [31:0] tx;
        logic [31:0] rx;
    } row_t;

    logic                   clock;
    logic                   rst_n;
    logic [`SPI_APB_AW-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   sclk;
    logic                   mosi;
    logic                   miso;
    logic                   ss_n;
    logic                   irq;

    // Slave setup for the current row
    logic        s_cpol;
    logic        s_cpha;
    logic        s_lsb;
    logic [5:0]  s_len;
    logic [31:0] s_reply;
    logic [31:0] slave_word;

    // Pin levels seen during the last APB access phase
    logic pin_ss_n;
    logic pin_sclk;
    logic pin_mosi;
    logic pin_irq;

    row_t   rows[$];
    integer seed;
    int     test_errs;
    int     pass_count;
    int     fail_count;
    longint watchdog_ns;
    bit     table_ready = 1'b0;

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    spi_top i_spi_top (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .sclk    (sclk),
        .mosi    (mosi),
        .miso    (miso),
        .ss_n    (ss_n),
        .irq     (irq)
    );

    spi_slave_model i_slave (
        .sclk      (sclk),
        .mosi      (mosi),
        .ss_n      (ss_n),
        .cpol      (s_cpol),
        .cpha      (s_cpha),
        .lsb_first (s_lsb),
        .len       (s_len),
        .reply     (s_reply),
        .miso      (miso),
        .captured  (slave_word)
    );

    task automatic flag_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, sig, got, exp);
        test_errs++;
    endtask

    task automatic flag_failure(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, test_errs);
        end
    endtask

    // One APB transfer with setup and access phase and no wait states
    task automatic apb_access(input logic wr, input logic [`SPI_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        // Responses settle within the access cycle
        @(negedge clock);
        rdata    = prdata;
        err      = pslverr;
        pin_ss_n = ss_n;
        pin_sclk = sclk;
        pin_mosi = mosi;
        pin_irq  = irq;
        if (pready !== 1'b1) flag_mismatch("pready", pready, 1'b1);
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic build_table();
        row_t r;
        int   rand_len[4];
        int   max_div;

        rows.push_back(row_t'{"mode0_msb_8", 1'b0, 1'b0, 1'b0, 8, 1, 32'hA5, 32'h3C});
        rows.push_back(row_t'{"mode1_lsb_8", 1'b0, 1'b1, 1'b1, 8, 0, 32'h96, 32'h15A});
        rows.push_back(row_t'{"mode2_msb_13", 1'b1, 1'b0, 1'b0, 13, 2, 32'h1ABC, 32'h0F35});
        rows.push_back(row_t'{"mode3_lsb_13", 1'b1, 1'b1, 1'b1, 13, 1, 32'hFFFF_E234,
                              32'hFFFF_0A5C});
        rows.push_back(row_t'{"mode0_lsb_1", 1'b0, 1'b0, 1'b1, 1, 3, 32'h1, 32'h1});
        rows.push_back(row_t'{"mode3_msb_1", 1'b1, 1'b1, 1'b0, 1, 0, 32'hFFFF_FFFE, 32'h3});
        rows.push_back(row_t'{"mode1_msb_32", 1'b0, 1'b1, 1'b0, 32, 0, 32'hDEAD_BEEF,
                              32'h1234_5678});
        rows.push_back(row_t'{"mode2_lsb_32", 1'b1, 1'b0, 1'b1, 32, 1, 32'h8000_0001,
                              32'hC001_D00D});

        // Random words in every mode
        rand_len = '{32, 13, 8, 1};
        for (int i = 0; i < 4; i++) begin
            r.name = $sformatf("random_mode%0d", i);
            r.cpol = i[1];
            r.cpha = i[0];
            r.lsb  = ~i[0];
            r.len  = rand_len[i];
            r.div  = i;
            r.tx   = $random(seed);
            r.rx   = $random(seed);
            rows.push_back(r);
        end

        max_div = 0;
        foreach (rows[i]) begin
            if (rows[i].div > max_div) max_div = rows[i].div;
        end
        // Worst transfer plus APB overhead for each row
        watchdog_ns = longint'(rows.size() + 2) * CLK_NS *
                      (1 + `SPI_LEAD_CYCLES + `SPI_LAG_CYCLES + 100 +
                       2 * `SPI_MAX_BITS * (max_div + 1)) + 1000;
    endtask

    task automatic run_row(input row_t r);
        logic [31:0] mask;
        logic [31:0] ctrl;
        logic [31:0] rdata;
        logic        err;
        int          latency;
        int          cycles;
        time         t_start;

        test_errs = 0;
        mask = (r.len >= 32) ? 32'hFFFF_FFFF : ((32'd1 << r.len) - 32'd1);
        latency = 1 + `SPI_LEAD_CYCLES + 2 * r.len * (r.div + 1) + `SPI_LAG_CYCLES;
        ctrl = '0;
        ctrl[0] = r.cpol;
        ctrl[1] = r.cpha;
        ctrl[2] = r.lsb;
        ctrl[12:8] = 5'(r.len - 1);
        s_cpol = r.cpol;
        s_cpha = r.cpha;
        s_lsb = r.lsb;
        s_len = 6'(r.len);
        s_reply = r.rx;

        apb_access(1'b1, `SPI_REG_CTRL, ctrl, rdata, err);
        apb_access(1'b1, `SPI_REG_DIV, 32'(r.div), rdata, err);
        apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h0) flag_mismatch("STATUS before start", rdata, 32'h0);
        if (pin_sclk !== r.cpol) flag_mismatch("sclk idle", pin_sclk, r.cpol);
        if (pin_ss_n !== 1'b1) flag_mismatch("ss_n idle", pin_ss_n, 1'b1);

        apb_access(1'b1, `SPI_REG_TX, r.tx, rdata, err);
        t_start = $time;
        if (err !== 1'b0) flag_mismatch("pslverr on TX write", err, 1'b0);
        // Retry during the transfer is refused
        apb_access(1'b1, `SPI_REG_TX, ~r.tx, rdata, err);
        if (err !== 1'b1) flag_mismatch("pslverr on busy TX write", err, 1'b1);

        rdata = 32'h1;
        cycles = 0;
        while (rdata[0] === 1'b1 && cycles <= latency + 8) begin
            apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
            cycles = int'(($time - t_start) / CLK_NS);
            if (rdata[0] === 1'b1 && pin_ss_n !== 1'b0) begin
                flag_mismatch("ss_n while busy", pin_ss_n, 1'b0);
            end
        end
        if (rdata[0] !== 1'b0) begin
            flag_failure($sformatf("busy still set %0d cycles after the TX write", cycles));
        end else if (cycles < latency - 1 || cycles > latency + 3) begin
            flag_failure($sformatf("transfer took %0d cycles, expected %0d", cycles, latency));
        end
        if (rdata[1] !== 1'b1) flag_mismatch("STATUS.done", rdata[1], 1'b1);
        if (pin_irq !== 1'b1) flag_mismatch("irq after transfer", pin_irq, 1'b1);
        if (pin_ss_n !== 1'b1) flag_mismatch("ss_n after transfer", pin_ss_n, 1'b1);
        if (pin_sclk !== r.cpol) flag_mismatch("sclk after transfer", pin_sclk, r.cpol);
        if (slave_word !== (r.tx & mask)) begin
            flag_mismatch("slave mosi word", slave_word, r.tx & mask);
        end

        apb_access(1'b0, `SPI_REG_RX, '0, rdata, err);
        if (rdata !== (r.rx & mask)) flag_mismatch("RX", rdata, r.rx & mask);
        apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h0) flag_mismatch("STATUS after RX read", rdata, 32'h0);
        if (pin_irq !== 1'b0) flag_mismatch("irq after RX read", pin_irq, 1'b0);
        finish_test(r.name);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;

        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        s_cpol     = 1'b0;
        s_cpha     = 1'b0;
        s_lsb      = 1'b0;
        s_len      = 6'd1;
        s_reply    = '0;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        seed       = 32'hb0d8_772b;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;

        test_errs = 0;
        apb_access(1'b0, `SPI_REG_CTRL, '0, rdata, err);
        if (rdata !== 32'h0) flag_mismatch("CTRL after reset", rdata, 32'h0);
        apb_access(1'b0, `SPI_REG_DIV, '0, rdata, err);
        if (rdata !== 32'h0) flag_mismatch("DIV after reset", rdata, 32'h0);
        apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
        if (rdata !== 32'h0) flag_mismatch("STATUS after reset", rdata, 32'h0);
        if (pin_ss_n !== 1'b1) flag_mismatch("ss_n after reset", pin_ss_n, 1'b1);
        if (pin_sclk !== 1'b0) flag_mismatch("sclk after reset", pin_sclk, 1'b0);
        if (pin_mosi !== 1'b0) flag_mismatch("mosi after reset", pin_mosi, 1'b0);
        if (pin_irq !== 1'b0) flag_mismatch("irq after reset", pin_irq, 1'b0);
        finish_test("reset_values");

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        test_errs = 0;
        apb_access(1'b0, 8'h20, '0, rdata, err);
        if (err !== 1'b1) flag_mismatch("pslverr on read of 0x20", err, 1'b1);
        apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, rdata, err);
        if (err !== 1'b1) flag_mismatch("pslverr on write to 0x20", err, 1'b1);
        finish_test("unmapped_offset");

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Ends a hung run once the whole table had time to complete
    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the transfers did not complete", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/spi_pkg.sv
logic/spi_cfg_if.sv
logic/spi_apb_regs.sv
logic/spi_edge_timer.sv
logic/spi_shift_engine.sv
logic/spi_frame_ctrl.sv
logic/spi_top.sv
testbench/spi_slave_model.sv
testbench/spi_tb.sv

/* Bender.yml */
package:
  name: spi_apb_master

export_include_dirs:
  - logic

sources:
  - logic/spi_pkg.sv
  - logic/spi_cfg_if.sv
  - logic/spi_apb_regs.sv
  - logic/spi_edge_timer.sv
  - logic/spi_shift_engine.sv
  - logic/spi_frame_ctrl.sv
  - logic/spi_top.sv
  - target: test
    files:
      - testbench/spi_slave_model.sv
      - testbench/spi_tb.sv
